// ==== cd_sys_pkg.sv ====
`default_nettype none

package cd_sys_pkg;

	// ========================================
	// Widths and timing
	// ========================================
	localparam int addr_w = 24;
	localparam int data_w = 16;
	localparam int count_w = 32;
	localparam int wait_w = 8;
	localparam int mclk_hz = 96671316;
	localparam int dma_rw_cycles = mclk_hz / 4800000; // Min strobe length in cycles

	// ========================================
	// Host register window, byte offsets
	// ========================================
	localparam logic [addr_w-1:0] regs_base = 24'hFF0000;
	localparam logic [8:0] reg_dma_start = 9'h061; // Bit 6 starts
	localparam logic [8:0] reg_addr_a_hi = 9'h064;
	localparam logic [8:0] reg_addr_a_lo = 9'h066;
	localparam logic [8:0] reg_addr_b_hi = 9'h068;
	localparam logic [8:0] reg_addr_b_lo = 9'h06A;
	localparam logic [8:0] reg_fill = 9'h06C; // Upper half of fill value only
	localparam logic [8:0] reg_count_hi = 9'h070;
	localparam logic [8:0] reg_count_lo = 9'h072;
	localparam logic [8:0] reg_ucode0 = 9'h07E;
	localparam logic [8:0] reg_area = 9'h105;
	localparam logic [8:0] reg_spr_dis = 9'h111;
	localparam logic [8:0] reg_fix_dis = 9'h115;
	localparam logic [8:0] reg_video_en = 9'h119;
	localparam logic [8:0] reg_map_spr = 9'h121;
	localparam logic [8:0] reg_map_pcm = 9'h123;
	localparam logic [8:0] reg_map_z80 = 9'h127;
	localparam logic [8:0] reg_map_fix = 9'h129;
	localparam logic [8:0] reg_unmap_spr = 9'h141;
	localparam logic [8:0] reg_unmap_pcm = 9'h143;
	localparam logic [8:0] reg_unmap_z80 = 9'h147;
	localparam logic [8:0] reg_unmap_fix = 9'h149;
	localparam logic [8:0] reg_bank_spr = 9'h1A1;
	localparam logic [8:0] reg_bank_pcm = 9'h1A3;

	// Microcode word 0 values seen from the BIOS
	localparam logic [15:0] mc_copy_word_a = 16'hFE6D;
	localparam logic [15:0] mc_copy_word_b = 16'hFE3D;
	localparam logic [15:0] mc_copy_byte_a = 16'hF2DD;
	localparam logic [15:0] mc_copy_byte_b = 16'hE2DD;
	localparam logic [15:0] mc_fill_a = 16'hFFCD;
	localparam logic [15:0] mc_fill_b = 16'hFFDD;

	// Upload areas
	localparam logic [2:0] area_spr = 3'd0;
	localparam logic [2:0] area_pcm = 3'd1;
	localparam logic [2:0] area_z80 = 3'd4;
	localparam logic [2:0] area_fix = 3'd5;
	localparam logic [3:0] upload_zone = 4'hE; // 0xE00000 zone

	// Output word select for the datapath
	localparam logic [1:0] out_hold = 2'd0;
	localparam logic [1:0] out_read = 2'd1;
	localparam logic [1:0] out_swap = 2'd2;
	localparam logic [1:0] out_fill = 2'd3;

	typedef enum logic [1:0] {dma_copy_word, dma_copy_byte, dma_fill} dma_mode_t;

	typedef enum logic [3:0] {
		dma_idle, dma_bus_req, dma_wait_grant, dma_wait_free, dma_start,
		dma_read, dma_read_done, dma_write, dma_write_done, dma_word_done
	} dma_state_t;

endpackage

`default_nettype wire

// ==== dma_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dma_cfg_if
	import cd_sys_pkg::*;
();
	logic start; // One cycle
	dma_mode_t mode;
	logic [addr_w-1:0] addr_a;
	logic [addr_w-1:0] addr_b;
	logic [data_w-1:0] fill_value;
	logic [count_w-1:0] count; // In words

	modport regs (output start, mode, addr_a, addr_b, fill_value, count);
	modport engine (input start, mode, addr_a, addr_b, fill_value, count);
endinterface

`default_nettype wire

// ==== dma_step_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dma_step_if;
	// All single-cycle, taken on the same edge
	logic load;
	logic latch_read;
	logic [1:0] word_out_select; // out_hold/read/swap/fill
	logic advance_in;
	logic advance_out;

	modport seq (output load, latch_read, word_out_select, advance_in, advance_out);
	modport data (input load, latch_read, word_out_select, advance_in, advance_out);
endinterface

`default_nettype wire

// ==== cd_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cd_host_regs
	import cd_sys_pkg::*;
(
	input logic clk_sys,
	input logic nRESET,
	input logic clk_68k_en,
	input logic [addr_w-1:1] m68k_addr,
	input logic [data_w-1:0] m68k_data_in,
	input logic m68k_rw,
	input logic nlds,
	input logic nuds,
	input logic system_cdx,
	input logic dma_running,
	input logic [addr_w-1:0] dma_addr_out,
	input logic dma_rd,
	input logic dma_wr,
	dma_cfg_if.regs cfg,
	output logic cd_video_en,
	output logic cd_fix_en,
	output logic cd_spr_en,
	output logic [1:0] cd_bank_spr,
	output logic cd_bank_pcm,
	output logic cd_tr_wr_spr,
	output logic cd_tr_wr_pcm,
	output logic cd_tr_wr_z80,
	output logic cd_tr_wr_fix,
	output logic cd_tr_rd_spr,
	output logic cd_tr_rd_pcm,
	output logic cd_tr_rd_z80,
	output logic cd_tr_rd_fix,
	output logic [data_w-1:0] cd_tr_wr_data,
	output logic [19:1] cd_tr_wr_addr
);
	logic nlds_prev, nuds_prev;
	logic [15:0] ucode0;
	logic [2:0] tr_area;
	logic use_spr, use_pcm, use_z80, use_fix; // Map flags
	logic wr_edge, regs_hit, upload_hit;
	logic word_lanes, low_lane, odd_only;
	logic tr_zone, tr_zone_rd, tr_zone_wr, any_lane;

	assign wr_edge = clk_68k_en & system_cdx & ((nlds_prev & ~nlds) | (nuds_prev & ~nuds));
	assign regs_hit = (m68k_addr[addr_w-1:9] == regs_base[addr_w-1:9]) & ~m68k_rw;
	assign upload_hit = (m68k_addr[addr_w-1:20] == upload_zone) & ~m68k_rw;
	assign word_lanes = ~nuds & ~nlds;
	assign low_lane = ~nlds;
	assign odd_only = nuds & ~nlds;

	// ========================================
	// CPU register writes
	// ========================================
	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			nlds_prev <= 1'b1;
			nuds_prev <= 1'b1;
			cfg.start <= 1'b0;
			cfg.mode <= dma_copy_word;
			cd_video_en <= 1'b1;
			cd_fix_en <= 1'b1;
			cd_spr_en <= 1'b1;
			cd_bank_spr <= 2'd0;
			cd_bank_pcm <= 1'b0;
			tr_area <= area_spr;
			{use_spr, use_pcm, use_z80, use_fix} <= 4'b0000;
		end
		else
		begin
			cfg.start <= 1'b0; // Pulse only
			if (clk_68k_en)
			begin
				nlds_prev <= nlds;
				nuds_prev <= nuds;
			end
			if (wr_edge && regs_hit)
			begin
				case (m68k_addr[8:1])
					reg_dma_start[8:1]:
						if (odd_only && m68k_data_in[6])
						begin
							case (ucode0) // Unknown microcode ignores start
								mc_copy_word_a, mc_copy_word_b:
								begin
									cfg.mode <= dma_copy_word;
									cfg.start <= 1'b1;
								end
								mc_copy_byte_a, mc_copy_byte_b:
								begin
									cfg.mode <= dma_copy_byte;
									cfg.start <= 1'b1;
								end
								mc_fill_a, mc_fill_b:
								begin
									cfg.mode <= dma_fill;
									cfg.start <= 1'b1;
								end
								default: ;
							endcase
						end
					reg_addr_a_hi[8:1]: if (word_lanes) cfg.addr_a[23:16] <= m68k_data_in[7:0];
					reg_addr_a_lo[8:1]: if (word_lanes) cfg.addr_a[15:0] <= m68k_data_in;
					reg_addr_b_hi[8:1]: if (word_lanes) cfg.addr_b[23:16] <= m68k_data_in[7:0];
					reg_addr_b_lo[8:1]: if (word_lanes) cfg.addr_b[15:0] <= m68k_data_in;
					reg_fill[8:1]: if (word_lanes) cfg.fill_value <= m68k_data_in;
					reg_count_hi[8:1]: if (word_lanes) cfg.count[31:16] <= m68k_data_in;
					reg_count_lo[8:1]: if (word_lanes) cfg.count[15:0] <= m68k_data_in;
					reg_ucode0[8:1]: if (word_lanes) ucode0 <= m68k_data_in;
					reg_area[8:1]: if (low_lane) tr_area <= m68k_data_in[2:0];
					reg_spr_dis[8:1]: if (low_lane) cd_spr_en <= ~m68k_data_in[0];
					reg_fix_dis[8:1]: if (low_lane) cd_fix_en <= ~m68k_data_in[0];
					reg_video_en[8:1]: if (low_lane) cd_video_en <= m68k_data_in[0];
					reg_map_spr[8:1]: if (low_lane) use_spr <= 1'b1;
					reg_map_pcm[8:1]: if (low_lane) use_pcm <= 1'b1;
					reg_map_z80[8:1]: if (low_lane) use_z80 <= 1'b1;
					reg_map_fix[8:1]: if (low_lane) use_fix <= 1'b1;
					reg_unmap_spr[8:1]: if (low_lane) use_spr <= 1'b0;
					reg_unmap_pcm[8:1]: if (low_lane) use_pcm <= 1'b0;
					reg_unmap_z80[8:1]: if (low_lane) use_z80 <= 1'b0;
					reg_unmap_fix[8:1]: if (low_lane) use_fix <= 1'b0;
					reg_bank_spr[8:1]: if (low_lane) cd_bank_spr <= m68k_data_in[1:0];
					reg_bank_pcm[8:1]: if (low_lane) cd_bank_pcm <= m68k_data_in[0];
					default: ;
				endcase
			end
			else if (wr_edge && upload_hit)
			begin
				// Buffered upload write
				cd_tr_wr_data <= m68k_data_in;
				cd_tr_wr_addr <= m68k_addr[19:1];
			end
		end
	end

	// ========================================
	// Upload zone strobes
	// ========================================
	// DMA owns the bus while running
	assign any_lane = ~(nlds & nuds);
	assign tr_zone = system_cdx & (dma_running ? (dma_addr_out[addr_w-1:20] == upload_zone)
		: (m68k_addr[addr_w-1:20] == upload_zone));
	assign tr_zone_rd = tr_zone & (dma_running ? dma_rd : (m68k_rw & any_lane));
	assign tr_zone_wr = tr_zone & (dma_running ? dma_wr : (~m68k_rw & any_lane));

	assign cd_tr_wr_spr = tr_zone_wr & (tr_area == area_spr) & use_spr;
	assign cd_tr_wr_pcm = tr_zone_wr & (tr_area == area_pcm) & use_pcm;
	assign cd_tr_wr_z80 = tr_zone_wr & (tr_area == area_z80) & use_z80;
	assign cd_tr_wr_fix = tr_zone_wr & (tr_area == area_fix) & use_fix;
	assign cd_tr_rd_spr = tr_zone_rd & (tr_area == area_spr) & use_spr;
	assign cd_tr_rd_pcm = tr_zone_rd & (tr_area == area_pcm) & use_pcm;
	assign cd_tr_rd_z80 = tr_zone_rd & (tr_area == area_z80) & use_z80;
	assign cd_tr_rd_fix = tr_zone_rd & (tr_area == area_fix) & use_fix;
endmodule

`default_nettype wire

// ==== dma_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_sequencer
	import cd_sys_pkg::*;
(
	input logic clk_sys,
	input logic nRESET,
	input logic nbg,
	input logic nas,
	input logic ndtack,
	input logic dma_sdram_busy,
	input logic wait_idle,
	input logic count_zero,
	dma_cfg_if.engine cfg,
	dma_step_if.seq step,
	output logic nbr,
	output logic nbgack,
	output logic dma_running,
	output logic dma_rd,
	output logic dma_wr,
	output logic wait_load,
	output logic count_load,
	output logic count_dec
);
	dma_state_t state;
	logic [1:0] io_step; // Position inside one word
	logic go;
	logic do_read, do_write;
	logic [1:0] out_sel;

	// Busy freezes the FSM
	assign go = wait_idle & ~dma_sdram_busy;

	// ========================================
	// Per-word micro-sequence
	// ========================================
	always_comb
	begin
		do_read = 1'b0;
		do_write = 1'b0;
		out_sel = out_hold;
		case (cfg.mode)
			dma_copy_word:
				case (io_step)
					2'd0: do_read = 1'b1;
					2'd1:
					begin
						do_write = 1'b1;
						out_sel = out_read;
					end
					default: ;
				endcase
			dma_copy_byte:
				case (io_step)
					2'd0: do_read = 1'b1;
					2'd1:
					begin
						do_write = 1'b1;
						out_sel = out_swap; // Swapped first
					end
					2'd2:
					begin
						do_write = 1'b1;
						out_sel = out_read;
					end
					default: ;
				endcase
			dma_fill:
				if (io_step == 2'd0)
				begin
					do_write = 1'b1;
					out_sel = out_fill;
				end
			default: ;
		endcase
	end

	// Commands act on the edge that leaves the state
	assign step.load = (state == dma_idle) & cfg.start;
	assign count_load = (state == dma_idle) & cfg.start;
	assign step.word_out_select = (go && state == dma_start && !count_zero) ? out_sel : out_hold;
	assign wait_load = go & ((state == dma_read) | (state == dma_write));
	assign step.latch_read = go & (state == dma_read_done);
	assign step.advance_in = go & (state == dma_read_done);
	assign step.advance_out = go & (state == dma_write_done);
	assign count_dec = go & (state == dma_word_done);

	// ========================================
	// Main FSM
	// ========================================
	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			state <= dma_idle;
			io_step <= 2'd0;
			nbr <= 1'b1;
			nbgack <= 1'b1;
			dma_running <= 1'b0;
			dma_rd <= 1'b0;
			dma_wr <= 1'b0;
		end
		else if (state == dma_idle)
		begin
			if (cfg.start)
			begin
				io_step <= 2'd0;
				state <= dma_bus_req;
			end
		end
		else if (go)
		begin
			case (state)
				dma_bus_req:
				begin
					nbr <= 1'b0;
					state <= dma_wait_grant;
				end
				dma_wait_grant: if (!nbg) state <= dma_wait_free;
				dma_wait_free:
					if (nas && ndtack) // CPU cycle finished
					begin
						nbr <= 1'b1;
						nbgack <= 1'b0;
						dma_running <= 1'b1;
						state <= dma_start;
					end
				dma_start:
					if (count_zero)
					begin
						nbgack <= 1'b1; // Release bus
						dma_running <= 1'b0;
						state <= dma_idle;
					end
					else if (do_read)
						state <= dma_read;
					else if (do_write)
						state <= dma_write;
					else
						state <= dma_word_done;
				dma_read:
				begin
					dma_rd <= 1'b1;
					state <= dma_read_done;
				end
				dma_read_done:
				begin
					dma_rd <= 1'b0;
					io_step <= io_step + 2'd1;
					state <= dma_start;
				end
				dma_write:
				begin
					dma_wr <= 1'b1;
					state <= dma_write_done;
				end
				dma_write_done:
				begin
					dma_wr <= 1'b0;
					io_step <= io_step + 2'd1;
					state <= dma_start;
				end
				dma_word_done:
				begin
					io_step <= 2'd0;
					state <= dma_start;
				end
				default: state <= dma_idle;
			endcase
		end
	end
endmodule

`default_nettype wire

// ==== dma_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_counters
	import cd_sys_pkg::*;
(
	input logic clk_sys,
	input logic nRESET,
	input logic wait_load,
	input logic count_load,
	input logic count_dec,
	input logic [count_w-1:0] count_init,
	output logic wait_idle,
	output logic count_zero
);
	logic [wait_w-1:0] wait_cnt;
	logic [count_w-1:0] count_run; // Words left

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			wait_cnt <= '0;
			count_run <= '0;
		end
		else
		begin
			// Keeps ticking during back-pressure
			if (wait_load)
				wait_cnt <= wait_w'(dma_rw_cycles);
			else if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;

			if (count_load)
				count_run <= count_init;
			else if (count_dec)
				count_run <= count_run - 1'b1;
		end
	end

	assign wait_idle = (wait_cnt == '0);
	assign count_zero = (count_run == '0);
endmodule

`default_nettype wire

// ==== dma_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_datapath
	import cd_sys_pkg::*;
(
	input logic clk_sys,
	input logic nRESET,
	input logic [data_w-1:0] dma_data_in,
	dma_cfg_if.engine cfg,
	dma_step_if.data step,
	output logic [addr_w-1:0] dma_addr_in,
	output logic [addr_w-1:0] dma_addr_out,
	output logic [data_w-1:0] dma_data_out
);
	logic [data_w-1:0] rd_word; // Last word read

	// ========================================
	// Address registers
	// ========================================
	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			dma_addr_in <= '0;
			dma_addr_out <= '0;
		end
		else if (step.load)
		begin
			if (cfg.mode == dma_fill)
				dma_addr_out <= cfg.addr_a;
			else
			begin
				dma_addr_in <= cfg.addr_a;
				dma_addr_out <= cfg.addr_b;
			end
		end
		else
		begin
			if (step.advance_in)
				dma_addr_in <= dma_addr_in + addr_w'(2);
			if (step.advance_out)
				dma_addr_out <= dma_addr_out + addr_w'(2);
		end
	end

	// Data words
	always_ff @(posedge clk_sys)
	begin
		if (step.latch_read)
			rd_word <= dma_data_in;
		case (step.word_out_select)
			out_read: dma_data_out <= rd_word;
			out_swap: dma_data_out <= {rd_word[7:0], rd_word[15:8]}; // Odd byte to even lane
			out_fill: dma_data_out <= cfg.fill_value;
			default: ;
		endcase
	end
endmodule

`default_nettype wire

// ==== cd_sys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cd_sys_top
	import cd_sys_pkg::*;
(
	input logic clk_sys,
	input logic nRESET,
	input logic clk_68k_en,
	input logic [addr_w-1:1] m68k_addr,
	input logic [data_w-1:0] m68k_data_in,
	input logic m68k_rw,
	input logic nlds,
	input logic nuds,
	input logic nas,
	input logic ndtack,
	input logic system_cdx,
	input logic nbg,
	input logic dma_sdram_busy,
	input logic [data_w-1:0] dma_data_in,
	output logic cd_video_en,
	output logic cd_fix_en,
	output logic cd_spr_en,
	output logic [1:0] cd_bank_spr,
	output logic cd_bank_pcm,
	output logic cd_tr_wr_spr,
	output logic cd_tr_wr_pcm,
	output logic cd_tr_wr_z80,
	output logic cd_tr_wr_fix,
	output logic cd_tr_rd_spr,
	output logic cd_tr_rd_pcm,
	output logic cd_tr_rd_z80,
	output logic cd_tr_rd_fix,
	output logic [data_w-1:0] cd_tr_wr_data,
	output logic [19:1] cd_tr_wr_addr,
	output logic nbr,
	output logic nbgack,
	output logic dma_running,
	output logic dma_rd,
	output logic dma_wr,
	output logic [addr_w-1:0] dma_addr_in,
	output logic [addr_w-1:0] dma_addr_out,
	output logic [data_w-1:0] dma_data_out
);
	logic wait_load, wait_idle;
	logic count_load, count_dec, count_zero;

	dma_cfg_if cfg_bus();
	dma_step_if step_bus();

	cd_host_regs u_regs (
		.clk_sys(clk_sys), .nRESET(nRESET), .clk_68k_en(clk_68k_en),
		.m68k_addr(m68k_addr), .m68k_data_in(m68k_data_in), .m68k_rw(m68k_rw),
		.nlds(nlds), .nuds(nuds), .system_cdx(system_cdx),
		.dma_running(dma_running), .dma_addr_out(dma_addr_out),
		.dma_rd(dma_rd), .dma_wr(dma_wr), .cfg(cfg_bus.regs),
		.cd_video_en(cd_video_en), .cd_fix_en(cd_fix_en), .cd_spr_en(cd_spr_en),
		.cd_bank_spr(cd_bank_spr), .cd_bank_pcm(cd_bank_pcm),
		.cd_tr_wr_spr(cd_tr_wr_spr), .cd_tr_wr_pcm(cd_tr_wr_pcm),
		.cd_tr_wr_z80(cd_tr_wr_z80), .cd_tr_wr_fix(cd_tr_wr_fix),
		.cd_tr_rd_spr(cd_tr_rd_spr), .cd_tr_rd_pcm(cd_tr_rd_pcm),
		.cd_tr_rd_z80(cd_tr_rd_z80), .cd_tr_rd_fix(cd_tr_rd_fix),
		.cd_tr_wr_data(cd_tr_wr_data), .cd_tr_wr_addr(cd_tr_wr_addr)
	);

	// DMA engine
	dma_sequencer u_seq (
		.clk_sys(clk_sys), .nRESET(nRESET), .nbg(nbg), .nas(nas), .ndtack(ndtack),
		.dma_sdram_busy(dma_sdram_busy), .wait_idle(wait_idle), .count_zero(count_zero),
		.cfg(cfg_bus.engine), .step(step_bus.seq),
		.nbr(nbr), .nbgack(nbgack), .dma_running(dma_running),
		.dma_rd(dma_rd), .dma_wr(dma_wr), .wait_load(wait_load),
		.count_load(count_load), .count_dec(count_dec)
	);

	dma_counters u_cnt (
		.clk_sys(clk_sys), .nRESET(nRESET), .wait_load(wait_load),
		.count_load(count_load), .count_dec(count_dec), .count_init(cfg_bus.count),
		.wait_idle(wait_idle), .count_zero(count_zero)
	);

	dma_datapath u_data (
		.clk_sys(clk_sys), .nRESET(nRESET), .dma_data_in(dma_data_in),
		.cfg(cfg_bus.engine), .step(step_bus.data),
		.dma_addr_in(dma_addr_in), .dma_addr_out(dma_addr_out), .dma_data_out(dma_data_out)
	);
endmodule

`default_nettype wire

// ==== tb_cd_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cd_sys
	import cd_sys_pkg::*;
;
	localparam int total_words = 6 + 5 + 4 + 8;
	localparam int watchdog_cycles = total_words * 3 * (dma_rw_cycles + 4) * 4 + 5000;

	logic clk_sys, nRESET, clk_68k_en, m68k_rw, nlds, nuds, nas, ndtack, system_cdx, nbg;
	logic [addr_w-1:1] m68k_addr;
	logic [data_w-1:0] m68k_data_in, dma_data_in;
	logic dma_sdram_busy;
	logic cd_video_en, cd_fix_en, cd_spr_en, cd_bank_pcm;
	logic [1:0] cd_bank_spr;
	logic cd_tr_wr_spr, cd_tr_wr_pcm, cd_tr_wr_z80, cd_tr_wr_fix;
	logic cd_tr_rd_spr, cd_tr_rd_pcm, cd_tr_rd_z80, cd_tr_rd_fix;
	logic [data_w-1:0] cd_tr_wr_data, dma_data_out;
	logic [19:1] cd_tr_wr_addr;
	logic nbr, nbgack, dma_running, dma_rd, dma_wr;
	logic [addr_w-1:0] dma_addr_in, dma_addr_out;

	logic [15:0] mem [0:255]; // DMA source memory
	logic busy_plan [0:2047];
	logic busy_en;
	logic busy_at_edge = 1'b0;
	logic [31:0] lfsr_state;
	logic [7:0] tr_now, tr_seen;
	logic [23:0] rd_addr_log[$];
	logic [23:0] wr_addr_log[$];
	logic [15:0] wr_data_log[$];
	int errors, checks, strobe_errors;

	cd_sys_top uut (.*);

	assign tr_now = {cd_tr_wr_spr, cd_tr_wr_pcm, cd_tr_wr_z80, cd_tr_wr_fix,
		cd_tr_rd_spr, cd_tr_rd_pcm, cd_tr_rd_z80, cd_tr_rd_fix};

	initial
	begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) busy_at_edge <= dma_sdram_busy; // Value the FSM saw

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [15:0] model_word(input logic [23:0] addr);
		return mem[addr[8:1]];
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Fail at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	task automatic make_busy_plan();
		logic level;
		logic [31:0] bits;
		level = 1'b0;
		for (int i = 0; i < 2048; i++)
		begin
			take_bits(3, bits);
			if (bits[2:0] == 3'b111) // Toggle about every 8 cycles
				level = ~level;
			busy_plan[i] = level;
		end
	endtask

	// One 68k bus cycle with strobes sampled mid-cycle
	task automatic cpu_access(input logic [23:0] addr, input logic [15:0] data,
		input logic rw, input logic [1:0] lanes);
		@(negedge clk_sys);
		m68k_addr = addr[23:1];
		m68k_data_in = data;
		m68k_rw = rw;
		@(negedge clk_sys);
		nuds = ~lanes[1];
		nlds = ~lanes[0];
		@(negedge clk_sys);
		tr_seen = tr_now;
		@(negedge clk_sys);
		nuds = 1'b1;
		nlds = 1'b1;
		m68k_rw = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic reg_write(input logic [8:0] offset, input logic [15:0] data);
		cpu_access(regs_base | 24'(offset), data, 1'b0, offset[0] ? 2'b01 : 2'b11);
	endtask

	// Grant after a delay with the CPU cycle still open
	task automatic grant_bus();
		while (nbr)
			@(negedge clk_sys);
		repeat (3) @(negedge clk_sys);
		check("nbgack before grant", 32'(nbgack), 32'd1);
		nbg = 1'b0;
		nas = 1'b0;
		ndtack = 1'b0;
		repeat (4) @(negedge clk_sys);
		check("nbgack while bus busy", 32'(nbgack), 32'd1);
		check("dma_running while bus busy", 32'(dma_running), 32'd0);
		nas = 1'b1;
		ndtack = 1'b1;
		while (nbgack)
			@(negedge clk_sys);
		check("nbr at bus acknowledge", 32'(nbr), 32'd1);
		check("dma_running at bus acknowledge", 32'(dma_running), 32'd1);
	endtask

	task automatic run_dma(input logic [15:0] ucode, input logic [23:0] a,
		input logic [23:0] b, input logic [15:0] fill, input int n);
		reg_write(reg_addr_a_hi, {8'h00, a[23:16]});
		reg_write(reg_addr_a_lo, a[15:0]);
		reg_write(reg_addr_b_hi, {8'h00, b[23:16]});
		reg_write(reg_addr_b_lo, b[15:0]);
		reg_write(reg_fill, fill);
		reg_write(reg_count_hi, 16'(n >> 16));
		reg_write(reg_count_lo, 16'(n));
		reg_write(reg_ucode0, ucode);
		reg_write(reg_dma_start, 16'h0040);
		grant_bus();
		while (dma_running)
			@(negedge clk_sys);
		check("nbgack after transfer", 32'(nbgack), 32'd1);
		nbg = 1'b1;
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic registers_after_writes();
		check("cd_video_en", 32'(cd_video_en), 32'd1);
		check("cd_fix_en", 32'(cd_fix_en), 32'd1);
		check("cd_spr_en", 32'(cd_spr_en), 32'd1);
		check("upload strobes", 32'(tr_now), 32'd0);
		reg_write(reg_spr_dis, 16'h0001);
		reg_write(reg_fix_dis, 16'h0001);
		check("cd_spr_en", 32'(cd_spr_en), 32'd0);
		check("cd_fix_en", 32'(cd_fix_en), 32'd0);
		reg_write(reg_video_en, 16'h0000);
		check("cd_video_en", 32'(cd_video_en), 32'd0);
		reg_write(reg_video_en, 16'h0001);
		check("cd_video_en", 32'(cd_video_en), 32'd1);
		reg_write(reg_bank_spr, 16'h0002);
		reg_write(reg_bank_pcm, 16'h0001);
		check("cd_bank_spr", 32'(cd_bank_spr), 32'd2);
		check("cd_bank_pcm", 32'(cd_bank_pcm), 32'd1);
		reg_write(reg_spr_dis, 16'h0000);
		reg_write(reg_fix_dis, 16'h0000);
		check("cd_spr_en", 32'(cd_spr_en), 32'd1);
		check("cd_fix_en", 32'(cd_fix_en), 32'd1);
	endtask

	task automatic upload_gating();
		reg_write(reg_area, {13'h0, area_pcm});
		cpu_access(24'hE01234, 16'h0F0F, 1'b0, 2'b11); // PCM not mapped yet
		check("upload strobes", 32'(tr_seen), 32'h00);
		reg_write(reg_map_pcm, 16'h0001);
		cpu_access(24'hE00100, 16'h5AA5, 1'b0, 2'b11);
		check("upload strobes", 32'(tr_seen), 32'h40);
		cpu_access(24'hE00200, 16'h0000, 1'b1, 2'b11);
		check("upload strobes", 32'(tr_seen), 32'h04);
		reg_write(reg_area, {13'h0, area_fix});
		cpu_access(24'hE00080, 16'h2468, 1'b0, 2'b11);
		check("upload strobes", 32'(tr_seen), 32'h00);
		reg_write(reg_map_fix, 16'h0001);
		cpu_access(24'hE00300, 16'h1357, 1'b0, 2'b11);
		check("upload strobes", 32'(tr_seen), 32'h10);
		check("cd_tr_wr_data", 32'(cd_tr_wr_data), 32'h1357);
		check("cd_tr_wr_addr", 32'(cd_tr_wr_addr), 32'h00180);
		reg_write(reg_unmap_fix, 16'h0001);
		cpu_access(24'hE00300, 16'h1357, 1'b0, 2'b11);
		check("upload strobes", 32'(tr_seen), 32'h00);
	endtask

	task automatic unknown_microcode();
		reg_write(reg_ucode0, 16'h1234);
		reg_write(reg_dma_start, 16'h0040);
		repeat (10) @(negedge clk_sys);
		check("nbr after unknown microcode", 32'(nbr), 32'd1);
		check("dma_running after unknown microcode", 32'(dma_running), 32'd0);
	endtask

	task automatic fill_transfer(input logic [23:0] a, input logic [15:0] fill, input int n);
		int rd_base;
		int wr_base;
		rd_base = rd_addr_log.size();
		wr_base = wr_addr_log.size();
		run_dma(mc_fill_a, a, 24'h000000, fill, n);
		check("read count", 32'(rd_addr_log.size() - rd_base), 32'd0);
		check("write count", 32'(wr_addr_log.size() - wr_base), 32'(n));
		for (int k = 0; k < n && wr_base + k < wr_addr_log.size(); k++)
		begin
			check("dma_addr_out", 32'(wr_addr_log[wr_base + k]), 32'(a + 24'(2 * k)));
			check("dma_data_out", 32'(wr_data_log[wr_base + k]), 32'(fill));
		end
	endtask

	task automatic word_copy_transfer(input logic [15:0] ucode, input logic [23:0] a,
		input logic [23:0] b, input int n);
		int rd_base;
		int wr_base;
		rd_base = rd_addr_log.size();
		wr_base = wr_addr_log.size();
		run_dma(ucode, a, b, 16'h0000, n);
		check("read count", 32'(rd_addr_log.size() - rd_base), 32'(n));
		check("write count", 32'(wr_addr_log.size() - wr_base), 32'(n));
		for (int k = 0; k < n; k++)
		begin
			if (rd_base + k < rd_addr_log.size())
				check("dma_addr_in", 32'(rd_addr_log[rd_base + k]), 32'(a + 24'(2 * k)));
			if (wr_base + k < wr_addr_log.size())
			begin
				check("dma_addr_out", 32'(wr_addr_log[wr_base + k]), 32'(b + 24'(2 * k)));
				check("dma_data_out", 32'(wr_data_log[wr_base + k]),
					32'(model_word(a + 24'(2 * k))));
			end
		end
	endtask

	task automatic byte_copy_transfer(input logic [23:0] a, input logic [23:0] b, input int n);
		int rd_base;
		int wr_base;
		logic [15:0] w;
		logic [15:0] expected;
		rd_base = rd_addr_log.size();
		wr_base = wr_addr_log.size();
		run_dma(mc_copy_byte_b, a, b, 16'h0000, n);
		check("read count", 32'(rd_addr_log.size() - rd_base), 32'(n));
		check("write count", 32'(wr_addr_log.size() - wr_base), 32'(2 * n));
		for (int j = 0; j < 2 * n && wr_base + j < wr_addr_log.size(); j++)
		begin
			w = model_word(a + 24'(2 * (j / 2)));
			expected = (j % 2 == 0) ? {w[7:0], w[15:8]} : w; // Swapped first
			check("dma_addr_out", 32'(wr_addr_log[wr_base + j]), 32'(b + 24'(2 * j)));
			check("dma_data_out", 32'(wr_data_log[wr_base + j]), 32'(expected));
		end
	endtask

	// ========================================
	// Bus models and monitor
	// ========================================
	initial
	begin
		dma_data_in = '0;
		forever
		begin
			@(negedge clk_sys);
			if (dma_rd)
				dma_data_in <= model_word(dma_addr_in);
		end
	end

	initial
	begin : busy_player
		logic [10:0] idx;
		idx = '0;
		dma_sdram_busy = 1'b0;
		forever
		begin
			@(negedge clk_sys);
			if (busy_en)
			begin
				dma_sdram_busy <= busy_plan[idx];
				idx = idx + 11'd1;
			end
			else
				dma_sdram_busy <= 1'b0;
		end
	end

	initial
	begin : strobe_monitor
		logic rd_prev, wr_prev;
		rd_prev = 1'b0;
		wr_prev = 1'b0;
		strobe_errors = 0;
		forever
		begin
			@(negedge clk_sys);
			if (dma_rd && !rd_prev)
				rd_addr_log.push_back(dma_addr_in);
			if (dma_wr && !wr_prev)
			begin
				wr_addr_log.push_back(dma_addr_out);
				wr_data_log.push_back(dma_data_out);
			end
			if (((dma_rd && !rd_prev) || (dma_wr && !wr_prev)) && busy_at_edge)
			begin
				strobe_errors++;
				$display("At %0t a DMA strobe rose while dma_sdram_busy was high", $time);
			end
			rd_prev = dma_rd;
			wr_prev = dma_wr;
		end
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Timeout after %0d cycles, the DMA or bus handshake never finished",
			watchdog_cycles);
		$display("*** FAILED ***");
		$finish;
	end

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin : main_sequence
		logic [31:0] bits;
		nRESET = 1'b0;
		clk_68k_en = 1'b1;
		m68k_addr = '0;
		m68k_data_in = '0;
		m68k_rw = 1'b1;
		nlds = 1'b1;
		nuds = 1'b1;
		nas = 1'b1;
		ndtack = 1'b1;
		system_cdx = 1'b1;
		nbg = 1'b1;
		busy_en = 1'b0;
		errors = 0;
		checks = 0;
		tr_seen = '0;
		lfsr_state = 32'h4c60_28f6;
		for (int i = 0; i < 256; i++)
		begin
			take_bits(16, bits);
			mem[i] = bits[15:0];
		end
		make_busy_plan();
		repeat (10) @(negedge clk_sys);
		nRESET = 1'b1;
		@(negedge clk_sys);

		registers_after_writes();
		upload_gating();
		unknown_microcode();
		fill_transfer(24'h200010, 16'hA5C3, 6);
		word_copy_transfer(mc_copy_word_a, 24'h100020, 24'h300000, 5);
		byte_copy_transfer(24'h100080, 24'h300100, 4);
		busy_en <= 1'b1; // Back-pressure run
		word_copy_transfer(mc_copy_word_b, 24'h100040, 24'h300200, 8);
		busy_en <= 1'b0;
		repeat (4) @(negedge clk_sys);

		$display("Checks: %0d, value errors: %0d, strobe errors: %0d",
			checks, errors, strobe_errors);
		if (errors == 0 && strobe_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end
endmodule

`default_nettype wire

// ==== cd_sys.f ====
cd_sys_pkg.sv
dma_cfg_if.sv
dma_step_if.sv
cd_host_regs.sv
dma_sequencer.sv
dma_counters.sv
dma_datapath.sv
cd_sys_top.sv
tb_cd_sys.sv

// ==== Makefile ====
# Verilator build for the CD system controller DMA project

TOP = tb_cd_sys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f cd_sys.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f cd_sys.f --top-module $(TOP) -o sim_cd_sys
	./obj_dir/sim_cd_sys | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
